// File: verif/decodeExecuteVectors.txt
// instrD pcD flushE wbEn wbRd wbData | checkMask regWriteE memWriteE resultSrcE rdE
// aluResultE writeDataE pcSrcE pcTargetE pcPlus4E (expected for the previous line)
FFC08293 00000100 0 1 01 0000000C 0FF 0 0 0 00 00000000 00000000 0 00000000 00000000
00208333 00000104 0 1 02 FFFFFFF0 15F 1 0 0 05 00000008 00000000 0 00000000 00000104
402083B3 00000108 0 1 03 0000000A 15F 1 0 0 06 FFFFFFFC 00000000 0 00000000 00000108
0030F433 0000010C 0 1 04 80000000 15F 1 0 0 07 0000001C 00000000 0 00000000 0000010C
0030E4B3 00000110 0 0 00 00000000 15F 1 0 0 08 00000008 00000000 0 00000000 00000110
0030C533 00000114 0 0 00 00000000 15F 1 0 0 09 0000000E 00000000 0 00000000 00000114
003095B3 00000118 0 0 00 00000000 15F 1 0 0 0A 00000006 00000000 0 00000000 00000118
40425613 0000011C 0 0 00 00000000 15F 1 0 0 0B 00003000 00000000 0 00000000 0000011C
003256B3 00000120 0 0 00 00000000 15F 1 0 0 0C F8000000 00000000 0 00000000 00000120
00112733 00000124 0 0 00 00000000 15F 1 0 0 0D 00200000 00000000 0 00000000 00000124
001137B3 00000128 0 0 00 00000000 15F 1 0 0 0E 00000001 00000000 0 00000000 00000128
12345837 0000012C 0 0 00 00000000 15F 1 0 0 0F 00000000 00000000 0 00000000 0000012C
80000897 00000130 0 0 00 00000000 15F 1 0 0 10 12345000 00000000 0 00000000 00000130
FF80A903 00000134 0 0 00 00000000 15F 1 0 0 11 80000130 00000000 0 00000000 00000134
0020AA23 00000138 0 0 00 00000000 15F 1 0 1 12 00000004 00000000 0 00000000 00000138
00108863 0000013C 0 0 00 00000000 177 0 1 0 00 00000020 FFFFFFF0 0 00000000 0000013C
00109863 00000140 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 1 0000014C 00000140
FE114CE3 00000144 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 0 00000150 00000144
00115863 00000148 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 1 0000013C 00000148
0020E863 0000014C 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 0 00000158 0000014C
0020F863 00000150 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 1 0000015C 00000150
100000EF 00000154 0 0 00 00000000 1C3 0 0 0 00 00000000 00000000 0 00000160 00000154
007082E7 00000158 0 0 00 00000000 1CF 1 0 2 01 00000000 00000000 1 00000254 00000158
00208A33 0000015C 1 1 00 DEADBEEF 1CF 1 0 2 05 00000000 00000000 1 00000012 0000015C
00000AB3 00000160 0 0 00 00000000 1FF 0 0 0 00 00000000 00000000 0 00000000 00000000
00000013 00000164 0 0 00 00000000 17F 1 0 0 15 00000000 00000000 0 00000000 00000164

// File: decodeExecute.f
logic/rvCorePkg.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/immExtend.sv
logic/idExReg.sv
logic/executeUnit.sv
logic/decodeExecute.sv
verif/clockGen.sv
verif/decodeExecuteTb.sv

// File: verif/decodeExecuteTb.sv
`timescale 1ns/1ns

module decodeExecuteTb;

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 8;
    localparam int fieldCount  = 16;
    localparam int maxVectors  = 64;

    // column positions within one vector line
    localparam int idxInstr     = 0;
    localparam int idxPc        = 1;
    localparam int idxFlush     = 2;
    localparam int idxWbEn      = 3;
    localparam int idxWbRd      = 4;
    localparam int idxWbData    = 5;
    localparam int idxMask      = 6;
    localparam int idxRegWrite  = 7;
    localparam int idxMemWrite  = 8;
    localparam int idxResultSrc = 9;
    localparam int idxRd        = 10;
    localparam int idxAluResult = 11;
    localparam int idxWriteData = 12;
    localparam int idxPcSrc     = 13;
    localparam int idxPcTarget  = 14;
    localparam int idxPcPlus4   = 15;

    logic        clk;
    logic        reset;
    logic        flushE;
    logic [31:0] instrD;
    logic [31:0] pcD;
    logic        wbEn;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        regWriteE;
    logic        memWriteE;
    logic        pcSrcE;
    logic [2:0]  resultSrcE;
    logic [4:0]  rdE;
    logic [31:0] aluResultE;
    logic [31:0] writeDataE;
    logic [31:0] pcTargetE;
    logic [31:0] pcPlus4E;

    logic [31:0] vecMem [0:fieldCount*maxVectors-1];
    int          vecCount;
    bit          vectorsLoaded;
    int          checkCount;
    int          errorCount;

    clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(resetCycles)) clockGen_i (
        .clk(clk), .reset(reset)
    );

    decodeExecute #(.XLEN(32)) dut_i (
        .clk(clk), .reset(reset), .flushE(flushE), .instrD(instrD), .pcD(pcD),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .regWriteE(regWriteE), .memWriteE(memWriteE), .pcSrcE(pcSrcE),
        .resultSrcE(resultSrcE), .rdE(rdE), .aluResultE(aluResultE),
        .writeDataE(writeDataE), .pcTargetE(pcTargetE), .pcPlus4E(pcPlus4E)
    );

    task automatic driveVector(input int v);
        int base;
        begin
            base = v * fieldCount;
            instrD <= vecMem[base + idxInstr];
            pcD    <= vecMem[base + idxPc];
            flushE <= vecMem[base + idxFlush][0];
            wbEn   <= vecMem[base + idxWbEn][0];
            wbRd   <= vecMem[base + idxWbRd][4:0];
            wbData <= vecMem[base + idxWbData];
        end
    endtask

    task automatic compareField(input int v, input string name, input logic enable,
                                input logic [31:0] expected, input logic [31:0] actual);
        begin
            if (enable)
            begin
                checkCount++;
                if (actual !== expected)
                begin
                    errorCount++;
                    $display("CHECK FAILED at %0t ns: vector %0d %s expected %h, got %h",
                             $time, v, name, expected, actual);
                end
            end
        end
    endtask

    // line v holds the expected outputs of the instruction from line v-1
    task automatic checkVector(input int v);
        int          base;
        logic [31:0] mask;
        begin
            base = v * fieldCount;
            mask = vecMem[base + idxMask];
            compareField(v, "regWriteE", mask[0], vecMem[base + idxRegWrite], regWriteE);
            compareField(v, "memWriteE", mask[1], vecMem[base + idxMemWrite], memWriteE);
            compareField(v, "resultSrcE", mask[2], vecMem[base + idxResultSrc], resultSrcE);
            compareField(v, "rdE", mask[3], vecMem[base + idxRd], rdE);
            compareField(v, "aluResultE", mask[4], vecMem[base + idxAluResult], aluResultE);
            compareField(v, "writeDataE", mask[5], vecMem[base + idxWriteData], writeDataE);
            compareField(v, "pcSrcE", mask[6], vecMem[base + idxPcSrc], pcSrcE);
            compareField(v, "pcTargetE", mask[7], vecMem[base + idxPcTarget], pcTargetE);
            compareField(v, "pcPlus4E", mask[8], vecMem[base + idxPcPlus4], pcPlus4E);
        end
    endtask

    initial
    begin
        flushE     = 1'b0;
        instrD     = '0;
        pcD        = '0;
        wbEn       = 1'b0;
        wbRd       = '0;
        wbData     = '0;
        checkCount = 0;
        errorCount = 0;
        vecCount   = 0;

        $readmemh("verif/decodeExecuteVectors.txt", vecMem);
        while (vecCount < maxVectors && !$isunknown(vecMem[vecCount * fieldCount]))
            vecCount++;
        if (vecCount == 0)
        begin
            errorCount++;
            $display("No vectors could be read from verif/decodeExecuteVectors.txt");
        end
        vectorsLoaded = 1'b1;

        @(negedge reset);
        @(negedge clk);
        checkVector(0); // reset bubble, before any instruction is captured
        for (int v = 0; v < vecCount; v++)
        begin
            @(posedge clk);
            driveVector(v);
            @(negedge clk); // outputs settled for the instruction captured at this edge
            checkVector(v);
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // watchdog sized from the vector count
    initial
    begin
        wait (vectorsLoaded);
        #((vecCount + resetCycles + 20) * clkPeriod);
        $display("Timeout: the vector run did not finish within the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: verif/clockGen.sv
`timescale 1ns/1ns

module clockGen
#(
    parameter int halfPeriod  = 5,
    parameter int resetCycles = 8
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0; // released on an edge, seen by the DUT from the next one
    end

    always #halfPeriod clk = ~clk;

endmodule

// File: logic/decodeExecute.sv
`timescale 1ns/1ns

module decodeExecute
    import rvCorePkg::*;
#(
    parameter int XLEN = 32
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flushE,
    input  logic [31:0]             instrD,
    input  logic [XLEN-1:0]         pcD,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbRd,
    input  logic [XLEN-1:0]         wbData,
    output logic                    regWriteE,
    output logic                    memWriteE,
    output logic                    pcSrcE,
    output resultSrcT               resultSrcE,
    output logic [regAddrWidth-1:0] rdE,
    output logic [XLEN-1:0]         aluResultE,
    output logic [XLEN-1:0]         writeDataE,
    output logic [XLEN-1:0]         pcTargetE,
    output logic [XLEN-1:0]         pcPlus4E
);

    logic            regWriteD, memWriteD, jumpD, jumpRegD, branchD, aluSrcAD, aluSrcBD;
    resultSrcT       resultSrcD;
    aluOpT           aluOpD, aluOpE;
    immSrcT          immSrcD;
    logic [XLEN-1:0] rd1D, rd2D, immExtD, pcPlus4D;
    logic            jumpE, jumpRegE, branchE, aluSrcAE, aluSrcBE;
    logic [XLEN-1:0] rd1E, rd2E, pcE, immExtE;
    logic [2:0]      funct3E;

    assign pcPlus4D = pcD + XLEN'(4);

    instrDecoder decoder_i (
        .instr(instrD), .regWrite(regWriteD), .memWrite(memWriteD), .jump(jumpD),
        .jumpReg(jumpRegD), .branch(branchD), .aluSrcA(aluSrcAD), .aluSrcB(aluSrcBD),
        .resultSrc(resultSrcD), .aluOp(aluOpD), .immSrc(immSrcD)
    );

    regFile #(.XLEN(XLEN)) regFile_i (
        .clk(clk), .reset(reset), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .rs1(instrD[19:15]), .rs2(instrD[24:20]), .rd1(rd1D), .rd2(rd2D)
    );

    immExtend #(.XLEN(XLEN)) immExtend_i (
        .instr(instrD), .immSrc(immSrcD), .immExt(immExtD)
    );

    // rs1E/rs2E are kept for a later hazard unit
    idExReg #(.XLEN(XLEN)) idExReg_i (
        .clk(clk), .reset(reset), .flush(flushE),
        .regWriteD(regWriteD), .memWriteD(memWriteD), .resultSrcD(resultSrcD),
        .jumpD(jumpD), .jumpRegD(jumpRegD), .branchD(branchD), .aluOpD(aluOpD),
        .aluSrcAD(aluSrcAD), .aluSrcBD(aluSrcBD),
        .regWriteE(regWriteE), .memWriteE(memWriteE), .resultSrcE(resultSrcE),
        .jumpE(jumpE), .jumpRegE(jumpRegE), .branchE(branchE), .aluOpE(aluOpE),
        .aluSrcAE(aluSrcAE), .aluSrcBE(aluSrcBE),
        .rd1D(rd1D), .rd2D(rd2D), .pcD(pcD), .pcPlus4D(pcPlus4D), .immExtD(immExtD),
        .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .pcPlus4E(pcPlus4E), .immExtE(immExtE),
        .rs1D(instrD[19:15]), .rs2D(instrD[24:20]), .rdD(instrD[11:7]),
        .rs1E(), .rs2E(), .rdE(rdE),
        .funct3D(instrD[14:12]), .funct3E(funct3E)
    );

    executeUnit #(.XLEN(XLEN)) executeUnit_i (
        .aluOp(aluOpE), .aluSrcA(aluSrcAE), .aluSrcB(aluSrcBE), .jump(jumpE),
        .jumpReg(jumpRegE), .branch(branchE), .funct3(funct3E),
        .rd1(rd1E), .rd2(rd2E), .pc(pcE), .immExt(immExtE),
        .aluResult(aluResultE), .writeData(writeDataE), .pcTarget(pcTargetE), .pcSrc(pcSrcE)
    );

endmodule

// File: logic/executeUnit.sv
`timescale 1ns/1ns

module executeUnit
    import rvCorePkg::*;
#(
    parameter int XLEN = 32
)
(
    input  aluOpT           aluOp,
    input  logic            aluSrcA,
    input  logic            aluSrcB,
    input  logic            jump,
    input  logic            jumpReg,
    input  logic            branch,
    input  logic [2:0]      funct3,
    input  logic [XLEN-1:0] rd1,
    input  logic [XLEN-1:0] rd2,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] immExt,
    output logic [XLEN-1:0] aluResult,
    output logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] pcTarget,
    output logic            pcSrc
);

    localparam int shamtWidth = $clog2(XLEN);

    logic [XLEN-1:0]       srcA;
    logic [XLEN-1:0]       srcB;
    logic [shamtWidth-1:0] shamt;
    logic [XLEN-1:0]       jalrSum;
    logic                  isEq;
    logic                  isLt;
    logic                  isLtu;
    logic                  taken;

    assign srcA  = aluSrcA ? pc : rd1;
    assign srcB  = aluSrcB ? immExt : rd2;
    assign shamt = srcB[shamtWidth-1:0];

    always_comb
    begin
        case (aluOp)
            aluSub:   aluResult = srcA - srcB;
            aluAnd:   aluResult = srcA & srcB;
            aluOr:    aluResult = srcA | srcB;
            aluXor:   aluResult = srcA ^ srcB;
            aluSll:   aluResult = srcA << shamt;
            aluSrl:   aluResult = srcA >> shamt;
            aluSra:   aluResult = $signed(srcA) >>> shamt;
            aluSlt:   aluResult = {{(XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  aluResult = {{(XLEN-1){1'b0}}, srcA < srcB};
            aluPassB: aluResult = srcB; // lui
            default:  aluResult = srcA + srcB;
        endcase
    end

    // branch compare always looks at the registers, not the ALU operands
    assign isEq  = (rd1 == rd2);
    assign isLt  = ($signed(rd1) < $signed(rd2));
    assign isLtu = (rd1 < rd2);

    always_comb
    begin
        case (funct3)
            3'b000:  taken = isEq;
            3'b001:  taken = !isEq;
            3'b100:  taken = isLt;
            3'b101:  taken = !isLt;
            3'b110:  taken = isLtu;
            3'b111:  taken = !isLtu;
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum   = rd1 + immExt;
    assign pcTarget  = jumpReg ? {jalrSum[XLEN-1:1], 1'b0} : pc + immExt;
    assign pcSrc     = jump | (branch & taken);
    assign writeData = rd2;

endmodule

// File: logic/idExReg.sv
`timescale 1ns/1ns

module idExReg
    import rvCorePkg::*;
#(
    parameter int XLEN = 32
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,

    input  logic                    regWriteD,
    input  logic                    memWriteD,
    input  resultSrcT               resultSrcD,
    input  logic                    jumpD,
    input  logic                    jumpRegD,
    input  logic                    branchD,
    input  aluOpT                   aluOpD,
    input  logic                    aluSrcAD,
    input  logic                    aluSrcBD,

    output logic                    regWriteE,
    output logic                    memWriteE,
    output resultSrcT               resultSrcE,
    output logic                    jumpE,
    output logic                    jumpRegE,
    output logic                    branchE,
    output aluOpT                   aluOpE,
    output logic                    aluSrcAE,
    output logic                    aluSrcBE,

    input  logic [XLEN-1:0]         rd1D,
    input  logic [XLEN-1:0]         rd2D,
    input  logic [XLEN-1:0]         pcD,
    input  logic [XLEN-1:0]         pcPlus4D,
    input  logic [XLEN-1:0]         immExtD,
    output logic [XLEN-1:0]         rd1E,
    output logic [XLEN-1:0]         rd2E,
    output logic [XLEN-1:0]         pcE,
    output logic [XLEN-1:0]         pcPlus4E,
    output logic [XLEN-1:0]         immExtE,

    input  logic [regAddrWidth-1:0] rs1D,
    input  logic [regAddrWidth-1:0] rs2D,
    input  logic [regAddrWidth-1:0] rdD,
    output logic [regAddrWidth-1:0] rs1E,
    output logic [regAddrWidth-1:0] rs2E,
    output logic [regAddrWidth-1:0] rdE,

    input  logic [2:0]              funct3D,
    output logic [2:0]              funct3E
);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset || flush) // reset is async, flush only acts on the edge
        begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSrcE <= resAlu;
            jumpE      <= 1'b0;
            jumpRegE   <= 1'b0;
            branchE    <= 1'b0;
            aluOpE     <= aluAdd;
            aluSrcAE   <= 1'b0;
            aluSrcBE   <= 1'b0;
            rd1E       <= '0;
            rd2E       <= '0;
            pcE        <= '0;
            pcPlus4E   <= '0;
            immExtE    <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
            funct3E    <= '0;
        end
        else
        begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSrcE <= resultSrcD;
            jumpE      <= jumpD;
            jumpRegE   <= jumpRegD;
            branchE    <= branchD;
            aluOpE     <= aluOpD;
            aluSrcAE   <= aluSrcAD;
            aluSrcBE   <= aluSrcBD;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            pcE        <= pcD;
            pcPlus4E   <= pcPlus4D;
            immExtE    <= immExtD;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= rdD;
            funct3E    <= funct3D;
        end
    end

    // a store never writes the register file as well
    noDoubleWrite: assert property (@(posedge clk) disable iff (reset)
        !(regWriteE && memWriteE))
        else $error("regWriteE and memWriteE high together");

endmodule

// File: logic/immExtend.sv
`timescale 1ns/1ns

module immExtend
    import rvCorePkg::*;
#(
    parameter int XLEN = 32
)
(
    input  logic [31:0]     instr,
    input  immSrcT          immSrc,
    output logic [XLEN-1:0] immExt
);

    logic sign;

    assign sign = instr[31];

    always_comb
    begin
        case (immSrc)
            immS:    immExt = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{(XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    immExt = {{(XLEN-31){sign}}, instr[30:12], 12'b0};
            immJ:    immExt = {{(XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = {{(XLEN-12){sign}}, instr[31:20]}; // immI and unused codes
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ns

module regFile
    import rvCorePkg::*;
#(
    parameter int XLEN = 32
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbRd,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [XLEN-1:0]         wbData,
    output logic [XLEN-1:0]         rd1,
    output logic [XLEN-1:0]         rd2
);

    logic [XLEN-1:0] regs [1:31]; // x0 has no storage
    logic            wbLive;

    assign wbLive = wbEn && (wbRd != '0);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wbLive)
        begin
            regs[wbRd] <= wbData;
        end
    end

    // write-through so a same-cycle writeback is seen by decode
    always_comb
    begin
        if (rs1 == '0)
            rd1 = '0;
        else if (wbLive && wbRd == rs1)
            rd1 = wbData;
        else
            rd1 = regs[rs1];

        if (rs2 == '0)
            rd2 = '0;
        else if (wbLive && wbRd == rs2)
            rd2 = wbData;
        else
            rd2 = regs[rs2];
    end

    // a written register holds the new data from the next cycle on
    writeIsStored: assert property (@(posedge clk) disable iff (reset)
        wbLive |=> (regs[$past(wbRd)] == $past(wbData)))
        else $error("register write was not stored");

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder
    import rvCorePkg::*;
(
    input  logic [31:0] instr,
    output logic        regWrite,
    output logic        memWrite,
    output logic        jump,
    output logic        jumpReg,
    output logic        branch,
    output logic        aluSrcA,
    output logic        aluSrcB,
    output resultSrcT   resultSrc,
    output aluOpT       aluOp,
    output immSrcT      immSrc
);

    opcodeT      opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    aluOpT       funcOp;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    // ALU op for OP and OP-IMM, chosen by funct3
    always_comb
    begin
        case (funct3)
            3'b000:  funcOp = (opcode == opOp && funct7b5) ? aluSub : aluAdd; // addi has no sub
            3'b001:  funcOp = aluSll;
            3'b010:  funcOp = aluSlt;
            3'b011:  funcOp = aluSltu;
            3'b100:  funcOp = aluXor;
            3'b101:  funcOp = funct7b5 ? aluSra : aluSrl;
            3'b110:  funcOp = aluOr;
            default: funcOp = aluAnd;
        endcase
    end

    always_comb
    begin
        // bubble unless the opcode is known
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        branch    = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        resultSrc = resAlu;
        aluOp     = aluAdd;
        immSrc    = immI;
        case (opcode)
            opOp:
            begin
                regWrite = 1'b1;
                aluOp    = funcOp;
            end
            opOpImm:
            begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = funcOp;
            end
            opLoad:
            begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                resultSrc = resMem;
            end
            opStore:
            begin
                memWrite = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = immS;
            end
            opBranch:
            begin
                branch = 1'b1;
                aluOp  = aluSub;
                immSrc = immB;
            end
            opJal, opJalr:
            begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                jumpReg   = (opcode == opJalr);
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
                resultSrc = resPcPlus4;
                immSrc    = (opcode == opJal) ? immJ : immI;
            end
            opLui:
            begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = aluPassB;
                immSrc   = immU;
            end
            opAuipc:
            begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = immU;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/rvCorePkg.sv
package rvCorePkg;

    parameter int regAddrWidth = 5;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    // aluAdd must stay at zero so a cleared ID/EX register computes 0
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10
    } aluOpT;

    typedef enum logic [2:0] {
        resAlu     = 3'd0,
        resMem     = 3'd1,
        resPcPlus4 = 3'd2 // link value for jal/jalr
    } resultSrcT;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSrcT;

endpackage
